/* src/beam_combiner.sv */
// four channel lane wise sum, divided by four with half up rounding, into the beam register
`timescale 1ns/1ps
`default_nettype none

`include "beamform_macros.svh"

module beam_combiner (
    input  wire                          clock,
    input  wire                          resetn,
    input  wire                          enable,
    input  wire beamform_pkg::weighted_t weighted_in [`BF_CHANNELS],
    output beamform_pkg::beat_t          beam_data,
    output logic                         beam_last
);

    import beamform_pkg::*;

    // half an lsb after the divide
    localparam logic signed [`BF_ACC_W-1:0] ROUND_HALF = 1 <<< (`BF_SUM_SHIFT - 1);

    // running sums for the lane being worked on
    // the rounding term is preloaded so the sum and the rounding share one adder chain
    logic signed [`BF_ACC_W-1:0] acc_re;
    logic signed [`BF_ACC_W-1:0] acc_im;

    // sums after the arithmetic shift
    logic signed [`BF_ACC_W-1:0] shift_re;
    logic signed [`BF_ACC_W-1:0] shift_im;

    beat_t beam_next;

    always_comb begin
        acc_re   = '0;
        acc_im   = '0;
        shift_re = '0;
        shift_im = '0;
        for (int lane = 0; lane < `BF_LANES; lane++) begin
            acc_re = ROUND_HALF;
            acc_im = ROUND_HALF;
            for (int ch = 0; ch < `BF_CHANNELS; ch++) begin
                acc_re = acc_re + weighted_in[ch].data[lane].re;
                acc_im = acc_im + weighted_in[ch].data[lane].im;
            end
            shift_re = acc_re >>> `BF_SUM_SHIFT;
            shift_im = acc_im >>> `BF_SUM_SHIFT;
            // the divided sum is always inside the sample range
            beam_next[lane].re = shift_re[`BF_SAMPLE_W-1:0];
            beam_next[lane].im = shift_im[`BF_SAMPLE_W-1:0];
        end
    end

    // stage two, the beam register
    // all channels carry the same last, channel 0 stands for them
    always_ff @(posedge clock) begin
        if (!resetn) begin
            beam_data <= '0;
            beam_last <= 1'b0;
        end else if (enable) begin
            beam_data <= beam_next;
            beam_last <= weighted_in[0].last;
        end
    end

endmodule

`default_nettype wire

/* src/beam_control.sv */
// beamformer control, decides input acceptance, stage valids and the pipeline stall
`timescale 1ns/1ps
`default_nettype none

`include "beamform_macros.svh"

module beam_control (
    input  wire                    clock,
    input  wire                    resetn,
    input  wire [`BF_CHANNELS-1:0] chan_valid,
    input  wire                    m_ready,
    output logic                   s_ready,
    output logic                   accept,
    output logic                   enable,
    output logic                   stage1_valid,
    output logic                   beam_valid
);

    // set on the first edge after reset is released
    logic running;

    always_ff @(posedge clock) begin
        if (!resetn) begin
            running <= 1'b0;
        end else begin
            running <= 1'b1;
        end
    end

    // whole pipeline advances only while the sink takes data
    assign enable = m_ready;

    // ready follows the sink once out of reset
    assign s_ready = running & m_ready;

    // a beat needs every channel valid in the same cycle
    assign accept = s_ready & (&chan_valid);

    // stage one marks the weighted registers, stage two the beam register
    // both hold while stalled so no beat is lost or repeated
    always_ff @(posedge clock) begin
        if (!resetn) begin
            stage1_valid <= 1'b0;
            beam_valid   <= 1'b0;
        end else if (enable) begin
            stage1_valid <= accept;
            beam_valid   <= stage1_valid;
        end
    end

endmodule

`default_nettype wire

/* src/beamform_macros.svh */
// beamformer sizing, sample and weight widths and rounding shifts
`ifndef BEAMFORM_MACROS_SVH
`define BEAMFORM_MACROS_SVH

// antenna channels summed into one beam
`define BF_CHANNELS 4

// complex samples carried in one beat
`define BF_LANES 8

// signed sample width, applies to re and im alike
`define BF_SAMPLE_W 16

// signed weight width, a fraction with BF_WEIGHT_FRAC fractional bits
`define BF_WEIGHT_W 8
`define BF_WEIGHT_FRAC 7

// divide by four after the cross channel sum
`define BF_SUM_SHIFT 2

// complex product width
// two sample x weight products plus one bit of growth for the add
`define BF_PROD_W (`BF_SAMPLE_W + `BF_WEIGHT_W + 1)

// accumulator for the four channel sum, log2 of the channel count on top of a sample
`define BF_ACC_W (`BF_SAMPLE_W + `BF_SUM_SHIFT)

`endif

/* src/beamform_pkg.sv */
// beamformer data types for samples, weights, beats and the streams around them
`default_nettype none

`include "beamform_macros.svh"

package beamform_pkg;

    // one signed sample component
    typedef logic signed [`BF_SAMPLE_W-1:0] sample_t;

    // one signed weight component, Q1.7
    typedef logic signed [`BF_WEIGHT_W-1:0] weight_t;

    // complex sample, re in the upper half
    typedef struct packed {
        sample_t re;
        sample_t im;
    } cplx_sample_t;

    // complex channel weight, re in the upper half
    typedef struct packed {
        weight_t re;
        weight_t im;
    } cplx_weight_t;

    // all lanes of one beat, lane 0 in the low bits
    typedef cplx_sample_t [`BF_LANES-1:0] beat_t;

    // one channel input beat as it arrives at the block
    typedef struct packed {
        logic  valid;
        logic  last;
        beat_t data;
    } chan_in_t;

    // weighted beat of one channel inside the pipeline
    // validity is tracked once in the control block, not per channel
    typedef struct packed {
        logic  last;
        beat_t data;
    } weighted_t;

    // summed beam leaving the block
    typedef struct packed {
        logic  valid;
        logic  last;
        beat_t data;
    } beam_out_t;

endpackage

`default_nettype wire

/* src/beamformer_top.sv */
// four channel complex beamformer, weights each channel and sums them into one beam
`timescale 1ns/1ps
`default_nettype none

`include "beamform_macros.svh"

module beamformer_top (
    input  wire                             clock,
    input  wire                             resetn,
    input  wire beamform_pkg::chan_in_t     chan_in [`BF_CHANNELS],
    input  wire beamform_pkg::cplx_weight_t weights [`BF_CHANNELS],
    output logic                            s_ready,
    output beamform_pkg::beam_out_t         beam,
    input  wire                             m_ready
);

    import beamform_pkg::*;

    // valid of every channel gathered for the acceptance check
    logic [`BF_CHANNELS-1:0] chan_valid;

    // pipeline control
    logic accept;
    logic enable;
    logic beam_valid;

    // one weighted beat per channel from stage one
    weighted_t weighted [`BF_CHANNELS];

    // stage two outputs
    beat_t beam_data;
    logic  beam_last;

    // acceptance, stall and the stage valids
    // stage one valid stays inside control where it feeds the beam valid
    beam_control u_control (
        .clock        (clock),
        .resetn       (resetn),
        .chan_valid   (chan_valid),
        .m_ready      (m_ready),
        .s_ready      (s_ready),
        .accept       (accept),
        .enable       (enable),
        .stage1_valid (),
        .beam_valid   (beam_valid)
    );

    // one weighting stage per antenna channel
    for (genvar ch = 0; ch < `BF_CHANNELS; ch++) begin : g_chan
        assign chan_valid[ch] = chan_in[ch].valid;

        channel_weighting u_weighting (
            .clock     (clock),
            .resetn    (resetn),
            .enable    (enable),
            .accept    (accept),
            .weight_in (weights[ch]),
            .chan      (chan_in[ch]),
            .weighted  (weighted[ch])
        );
    end

    // cross channel sum
    // beam valid from control marks which of its results belong to accepted beats
    beam_combiner u_combiner (
        .clock       (clock),
        .resetn      (resetn),
        .enable      (enable),
        .weighted_in (weighted),
        .beam_data   (beam_data),
        .beam_last   (beam_last)
    );

    // output beam with valid from control and payload from the combiner
    assign beam = '{valid: beam_valid, last: beam_last, data: beam_data};

endmodule

`default_nettype wire

/* src/channel_weighting.sv */
// per channel complex weighting with half up rounding and 16 bit saturation
`timescale 1ns/1ps
`default_nettype none

`include "beamform_macros.svh"

module channel_weighting (
    input  wire                             clock,
    input  wire                             resetn,
    input  wire                             enable,
    input  wire                             accept,
    input  wire beamform_pkg::cplx_weight_t weight_in,
    input  wire beamform_pkg::chan_in_t     chan,
    output beamform_pkg::weighted_t         weighted
);

    import beamform_pkg::*;

    // half an lsb at the weight's fractional point
    localparam logic signed [`BF_PROD_W-1:0] ROUND_HALF = 1 <<< (`BF_WEIGHT_FRAC - 1);

    // saturation limits of a sample
    localparam logic signed [`BF_PROD_W-1:0] SAT_MAX = (1 <<< (`BF_SAMPLE_W - 1)) - 1;
    localparam logic signed [`BF_PROD_W-1:0] SAT_MIN = -(1 <<< (`BF_SAMPLE_W - 1));

    // weight is retimed every cycle
    cplx_weight_t weight_q;

    // full precision products of the lane being worked on
    logic signed [`BF_PROD_W-1:0] prod_re;
    logic signed [`BF_PROD_W-1:0] prod_im;

    // rounded and saturated beat, loaded on accept
    beat_t weighted_next;

    // round half up, drop the fraction, clamp to the sample range
    function automatic sample_t round_sat(input logic signed [`BF_PROD_W-1:0] prod);
        logic signed [`BF_PROD_W-1:0] scaled;
        scaled = (prod + ROUND_HALF) >>> `BF_WEIGHT_FRAC;
        if (scaled > SAT_MAX) begin
            return SAT_MAX[`BF_SAMPLE_W-1:0];
        end else if (scaled < SAT_MIN) begin
            return SAT_MIN[`BF_SAMPLE_W-1:0];
        end
        return scaled[`BF_SAMPLE_W-1:0];
    endfunction

    always_ff @(posedge clock) begin
        if (!resetn) begin
            weight_q <= '0;
        end else begin
            weight_q <= weight_in;
        end
    end

    // (wr + j wi)(xr + j xi)
    // operands are signed and extended to the product width before the multiply
    always_comb begin
        prod_re = '0;
        prod_im = '0;
        for (int lane = 0; lane < `BF_LANES; lane++) begin
            prod_re = weight_q.re * chan.data[lane].re - weight_q.im * chan.data[lane].im;
            prod_im = weight_q.re * chan.data[lane].im + weight_q.im * chan.data[lane].re;
            weighted_next[lane].re = round_sat(prod_re);
            weighted_next[lane].im = round_sat(prod_im);
        end
    end

    // stage one register
    // contents only matter when stage1_valid marks an accepted beat
    always_ff @(posedge clock) begin
        if (!resetn) begin
            weighted <= '0;
        end else if (enable && accept) begin
            weighted.last <= chan.last;
            weighted.data <= weighted_next;
        end
    end

endmodule

`default_nettype wire

/* verification/beamformer_tb.sv */
// testbench for the four channel beamformer, reference model, ready toggling and beam checks
`timescale 1ns/1ps
`default_nettype none

`include "beamform_macros.svh"

module beamformer_tb;

    import beamform_pkg::*;

    // burst sizes of the test phases
    localparam int LATENCY_BEATS  = 16;
    localparam int PARTIAL_BEATS  = 8;
    localparam int BP_BEATS       = 40;
    localparam int WEIGHT_BEATS   = 16;
    localparam int FULL_BEATS     = LATENCY_BEATS + PARTIAL_BEATS + BP_BEATS + WEIGHT_BEATS;
    localparam int DRIVEN_BEATS   = FULL_BEATS + PARTIAL_BEATS;
    localparam int CYCLE_LIMIT    = 4 * DRIVEN_BEATS + 200;

    logic         clock;
    logic         resetn;
    chan_in_t     chan_in [`BF_CHANNELS];
    cplx_weight_t weights [`BF_CHANNELS];
    logic         s_ready;
    beam_out_t    beam;
    logic         m_ready;

    integer seed;
    logic   random_ready;

    // reference results and the enabled edge count at their accept edge
    beam_out_t exp_q [$];
    int        stamp_q [$];
    int        en_count;
    int        beams_seen;
    int        cycle_count;
    logic      resetn_q;
    logic      reset_applied;

    beamformer_top UUT (
        .clock   (clock),
        .resetn  (resetn),
        .chan_in (chan_in),
        .weights (weights),
        .s_ready (s_ready),
        .beam    (beam),
        .m_ready (m_ready)
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Test failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            abort_run($sformatf("error at %0t: %s expected %b actual %b",
                                $time, name, expected, actual));
        end
    endtask

    task automatic check_beat(input string name, input beat_t expected, input beat_t actual);
        for (int lane = 0; lane < `BF_LANES; lane++) begin
            if (actual[lane] !== expected[lane]) begin
                abort_run($sformatf(
                    "error at %0t: %s[%0d] expected (%0d, %0d) actual (%0d, %0d)",
                    $time, name, lane, expected[lane].re, expected[lane].im,
                    actual[lane].re, actual[lane].im));
            end
        end
    endtask

    // weighted product back to sample scale
    // round half up at the weight's fraction and clamp to 16 bit signed
    function automatic longint scale_product(input longint prod);
        longint scaled;
        scaled = (prod + (1 << (`BF_WEIGHT_FRAC - 1))) >>> `BF_WEIGHT_FRAC;
        if (scaled > 32767) begin
            scaled = 32767;
        end else if (scaled < -32768) begin
            scaled = -32768;
        end
        return scaled;
    endfunction

    // expected beam for one accepted beat
    function automatic beam_out_t expected_beam(input beat_t beats [`BF_CHANNELS],
                                                input cplx_weight_t w [`BF_CHANNELS],
                                                input logic last_bit);
        beam_out_t result;
        longint    wr;
        longint    wi;
        longint    xr;
        longint    xi;
        longint    sum_re;
        longint    sum_im;
        result.valid = 1'b1;
        result.last  = last_bit;
        for (int lane = 0; lane < `BF_LANES; lane++) begin
            sum_re = 0;
            sum_im = 0;
            for (int ch = 0; ch < `BF_CHANNELS; ch++) begin
                wr = w[ch].re;
                wi = w[ch].im;
                xr = beats[ch][lane].re;
                xi = beats[ch][lane].im;
                sum_re += scale_product(wr * xr - wi * xi);
                sum_im += scale_product(wr * xi + wi * xr);
            end
            // divide by four, half up
            result.data[lane].re = sample_t'((sum_re + 2) >>> 2);
            result.data[lane].im = sample_t'((sum_im + 2) >>> 2);
        end
        return result;
    endfunction

    // samples draw the range ends often so that weighting saturates
    function automatic sample_t new_sample();
        case ({$random(seed)} % 8)
            0:       return 16'h7fff;
            1:       return 16'h8000;
            default: return sample_t'($random(seed));
        endcase
    endfunction

    function automatic weight_t pick_weight();
        case ({$random(seed)} % 6)
            0:       return 8'h7f;
            1:       return 8'h80;
            default: return weight_t'($random(seed));
        endcase
    endfunction

    function automatic beat_t make_beat();
        beat_t b;
        for (int lane = 0; lane < `BF_LANES; lane++) begin
            b[lane].re = new_sample();
            b[lane].im = new_sample();
        end
        return b;
    endfunction

    // one clock with m_ready random only in the back-pressure phase
    task automatic next_cycle();
        if (random_ready) begin
            m_ready <= ({$random(seed)} % 4) != 0;
        end else begin
            m_ready <= 1'b1;
        end
        @(posedge clock);
    endtask

    task automatic idle_cycles(input int count);
        for (int ch = 0; ch < `BF_CHANNELS; ch++) begin
            chan_in[ch].valid <= 1'b0;
        end
        repeat (count) next_cycle();
    endtask

    // hold the beat until an edge sees s_ready high
    task automatic send_beat(input logic last_bit);
        for (int ch = 0; ch < `BF_CHANNELS; ch++) begin
            chan_in[ch] <= '{valid: 1'b1, last: last_bit, data: make_beat()};
        end
        next_cycle();
        while (!s_ready) begin
            next_cycle();
        end
    endtask

    // one channel held back for three cycles so the beat is never accepted
    task automatic offer_partial_beat();
        int gap;
        gap = {$random(seed)} % `BF_CHANNELS;
        for (int ch = 0; ch < `BF_CHANNELS; ch++) begin
            chan_in[ch] <= '{valid: (ch != gap), last: 1'b0, data: make_beat()};
        end
        repeat (3) next_cycle();
    endtask

    // monitor and compare on every rising edge against the values from before the edge
    always @(posedge clock) begin : monitor
        beat_t     beats [`BF_CHANNELS];
        logic      all_valid;
        logic      out_of_reset;
        logic      exp_s_ready;
        logic      exp_valid;
        beam_out_t exp;
        all_valid = 1'b1;
        for (int ch = 0; ch < `BF_CHANNELS; ch++) begin
            beats[ch] = chan_in[ch].data;
            all_valid = all_valid & chan_in[ch].valid;
        end
        // s_ready low in reset and on the first edge after it
        out_of_reset = resetn && resetn_q;
        exp_s_ready  = out_of_reset ? m_ready : 1'b0;
        // registers are unknown until the first edge that sees reset
        if (reset_applied) begin
            check_bit("s_ready", exp_s_ready, s_ready);
            if (!out_of_reset) begin
                check_bit("beam.valid", 1'b0, beam.valid);
            end else begin
                // a beam is due two enabled edges after its accept edge
                exp_valid = (stamp_q.size() > 0) && (en_count - stamp_q[0] >= 2);
                check_bit("beam.valid", exp_valid, beam.valid);
                if (beam.valid && m_ready) begin
                    exp = exp_q.pop_front();
                    void'(stamp_q.pop_front());
                    check_beat("beam.data", exp.data, beam.data);
                    check_bit("beam.last", exp.last, beam.last);
                    beams_seen++;
                end
                if (all_valid && exp_s_ready) begin
                    exp_q.push_back(expected_beam(beats, weights, chan_in[0].last));
                    stamp_q.push_back(en_count);
                end
                if (m_ready) begin
                    en_count++;
                end
            end
        end
        if (!resetn) begin
            reset_applied = 1'b1;
        end
        resetn_q = resetn;
    end

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count > CYCLE_LIMIT) begin
            abort_run($sformatf("timeout after %0d cycles, %0d of %0d beams seen",
                                cycle_count, beams_seen, FULL_BEATS));
        end
    end

    initial begin : stimulus
        seed          = 34;
        resetn        = 1'b0;
        resetn_q      = 1'b0;
        reset_applied = 1'b0;
        m_ready       = 1'b1;
        random_ready  = 1'b0;
        en_count      = 0;
        beams_seen    = 0;
        cycle_count   = 0;
        for (int ch = 0; ch < `BF_CHANNELS; ch++) begin
            chan_in[ch] = '0;
        end
        // extreme weights on two channels force saturation
        weights[0] = '{re: 8'h80, im: 8'h80};
        weights[1] = '{re: 8'h7f, im: 8'h7f};
        weights[2] = '{re: pick_weight(), im: pick_weight()};
        weights[3] = '{re: pick_weight(), im: pick_weight()};

        repeat (8) @(posedge clock);
        resetn <= 1'b1;
        idle_cycles(2);

        // steady stream for latency and arithmetic
        for (int i = 0; i < LATENCY_BEATS; i++) begin
            send_beat(i == LATENCY_BEATS - 1);
        end
        idle_cycles(2);

        // partial valid between full beats
        for (int i = 0; i < PARTIAL_BEATS; i++) begin
            offer_partial_beat();
            send_beat(i == PARTIAL_BEATS - 1);
        end
        idle_cycles(2);

        // sink stalls at random
        random_ready = 1'b1;
        for (int i = 0; i < BP_BEATS; i++) begin
            send_beat(i % 8 == 7);
        end
        random_ready = 1'b0;
        idle_cycles(4);

        // new weights while idle and a fresh burst after them
        for (int ch = 0; ch < `BF_CHANNELS; ch++) begin
            weights[ch] <= '{re: pick_weight(), im: pick_weight()};
        end
        idle_cycles(2);
        for (int i = 0; i < WEIGHT_BEATS; i++) begin
            send_beat(i == WEIGHT_BEATS - 1);
        end
        idle_cycles(1);

        // drain and wait a few quiet cycles to catch any extra beam
        while (beams_seen < FULL_BEATS) begin
            @(negedge clock);
        end
        repeat (4) @(posedge clock);
        @(negedge clock);
        if (exp_q.size() == 0 && beams_seen == FULL_BEATS) begin
            $display("Test passed");
            $finish;
        end else begin
            abort_run($sformatf("%0d beams left unmatched, %0d seen", exp_q.size(), beams_seen));
        end
    end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+src
src/beamform_pkg.sv
src/beam_control.sv
src/channel_weighting.sv
src/beam_combiner.sv
src/beamformer_top.sv
verification/beamformer_tb.sv
